// File: logic/alu_config.svh
// widths and register map of the ALU accelerator, included by the package and the bus slave
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

// datapath width
`define ALU_XLEN 64

// wishbone byte address width
`define ALU_WB_AW 8

// register byte offsets, one 64-bit word each
`define ALU_REG_OPA    8'h00
`define ALU_REG_OPB    8'h08
`define ALU_REG_OP     8'h10

// read-only views of the ALU output
`define ALU_REG_RESULT 8'h18
`define ALU_REG_ADDER  8'h20
`define ALU_REG_FLAGS  8'h28

`endif

// File: logic/alu_pkg.sv
// shared types of the ALU accelerator: operator codes, ALU request/response and Wishbone structs
`include "alu_config.svh"

package alu_pkg;

  // operator codes, numeric order is the value written to the operator register
  typedef enum logic [4:0] {
    // adder
    ADD, SUB, ADDW, SUBW,
    // logic
    ANDL, ORL, XORL,
    // shifts
    SLL, SRL, SRA, SLLW, SRLW, SRAW,
    // comparisons
    EQ, NE, GTU, GEU, LTU, LEU, GTS, GES, LTS, LES,
    SLTS, SLTU, SLETS, SLETU
  } alu_op;

  // ------------------------------
  // ALU request and response
  // ------------------------------
  typedef struct packed {
    alu_op                operator;
    logic [`ALU_XLEN-1:0] operand_a;
    logic [`ALU_XLEN-1:0] operand_b;
  } alu_req_t;

  typedef struct packed {
    logic [`ALU_XLEN-1:0] result;
    logic [`ALU_XLEN-1:0] adder_result;
    logic                 comparison;
    logic                 is_equal;
  } alu_rsp_t;

  // ------------------------------
  // wishbone classic
  // ------------------------------
  typedef struct packed {
    logic                  cyc;
    logic                  stb;
    logic                  we;
    logic [`ALU_WB_AW-1:0] adr;
    logic [`ALU_XLEN-1:0]  dat;
  } wb_m2s_t;

  typedef struct packed {
    logic                 ack;
    logic [`ALU_XLEN-1:0] dat;
  } wb_s2m_t;

endpackage

// File: logic/alu.sv
// combinational integer ALU with adder, shifter and comparator, fed by the register slave
`timescale 1ns/1ps
`include "alu_config.svh"

module alu
  import alu_pkg::*;
(
  input  alu_req_t req_i,
  output alu_rsp_t rsp_o
);

  localparam int unsigned XLEN    = `ALU_XLEN;
  localparam int unsigned SHAMT_W = $clog2(XLEN);

  alu_op           op;
  logic [XLEN-1:0] opa;
  logic [XLEN-1:0] opb;

  assign op  = req_i.operator;
  assign opa = req_i.operand_a;
  assign opb = req_i.operand_b;

  // ------------------------------
  // adder
  // ------------------------------
  logic            negate_b;
  logic [XLEN:0]   adder_in_a;
  logic [XLEN:0]   adder_in_b;
  logic [XLEN:0]   adder_sum;
  logic [XLEN-1:0] adder_result;

  // subtract and every compare compute a - b
  always_comb
  begin
    unique case (op)
      SUB, SUBW,
      EQ, NE,
      GTU, GEU, LTU, LEU,
      GTS, GES, LTS, LES,
      SLTS, SLTU, SLETS, SLETU: negate_b = 1'b1;
      default:                  negate_b = 1'b0;
    endcase
  end

  // extra low bit carries the +1 of the two's complement
  assign adder_in_a   = {opa, 1'b1};
  assign adder_in_b   = {opb, 1'b0} ^ {(XLEN+1){negate_b}};
  assign adder_sum    = adder_in_a + adder_in_b;
  assign adder_result = adder_sum[XLEN:1];

  // ------------------------------
  // shifter
  // ------------------------------
  logic            shift_left;
  logic            shift_arith;
  logic [XLEN-1:0] opa_rev;
  logic [31:0]     opa_rev32;
  logic [XLEN-1:0] shift_in;
  logic [31:0]     shift_in32;
  logic [XLEN:0]   shr_result;
  logic [32:0]     shr_result32;
  logic [XLEN-1:0] shift_result;
  logic [31:0]     shift_result32;

  assign shift_left  = (op == SLL) || (op == SLLW);
  assign shift_arith = (op == SRA) || (op == SRAW);

  // left shifts run through the right shifter on reversed bits
  always_comb
  begin
    for (int i = 0; i < XLEN; i++)
      opa_rev[i] = opa[XLEN-1-i];
    for (int i = 0; i < 32; i++)
      opa_rev32[i] = opa[31-i];
  end

  assign shift_in   = shift_left ? opa_rev : opa;
  assign shift_in32 = shift_left ? opa_rev32 : opa[31:0];

  // top bit fills with the sign only for arithmetic shifts
  assign shr_result   = $signed({shift_arith & shift_in[XLEN-1], shift_in}) >>> opb[SHAMT_W-1:0];
  assign shr_result32 = $signed({shift_arith & shift_in32[31], shift_in32}) >>> opb[4:0];

  always_comb
  begin
    for (int i = 0; i < XLEN; i++)
      shift_result[i] = shift_left ? shr_result[XLEN-1-i] : shr_result[i];
    for (int i = 0; i < 32; i++)
      shift_result32[i] = shift_left ? shr_result32[31-i] : shr_result32[i];
  end

  // ------------------------------
  // comparator
  // ------------------------------
  logic cmp_signed;
  logic is_equal;
  logic is_ge;
  logic cmp_result;

  always_comb
  begin
    unique case (op)
      GTS, GES, LTS, LES, SLTS, SLETS: cmp_signed = 1'b1;
      default:                         cmp_signed = 1'b0;
    endcase
  end

  assign is_equal = (adder_result == '0);

  // on differing signs operand a alone decides
  always_comb
  begin
    if (opa[XLEN-1] == opb[XLEN-1])
      is_ge = ~adder_result[XLEN-1];
    else
      is_ge = opa[XLEN-1] ^ cmp_signed;
  end

  always_comb
  begin
    unique case (op)
      EQ:                     cmp_result = is_equal;
      NE:                     cmp_result = ~is_equal;
      GTU, GTS:               cmp_result = is_ge & ~is_equal;
      GEU, GES:               cmp_result = is_ge;
      LTU, LTS, SLTU, SLTS:   cmp_result = ~is_ge;
      LEU, LES, SLETU, SLETS: cmp_result = ~is_ge | is_equal;
      default:                cmp_result = 1'b0;
    endcase
  end

  // ------------------------------
  // result mux
  // ------------------------------
  logic [XLEN-1:0] result;

  always_comb
  begin
    unique case (op)
      ANDL:             result = opa & opb;
      ORL:              result = opa | opb;
      XORL:             result = opa ^ opb;
      ADD, SUB:         result = adder_result;
      // word forms keep 32 bits, sign extended
      ADDW, SUBW:       result = {{(XLEN-32){adder_result[31]}}, adder_result[31:0]};
      SLL, SRL, SRA:    result = shift_result;
      SLLW, SRLW, SRAW: result = {{(XLEN-32){shift_result32[31]}}, shift_result32};
      default:          result = {{(XLEN-1){1'b0}}, cmp_result};
    endcase
  end

  assign rsp_o.result       = result;
  assign rsp_o.adder_result = adder_result;
  assign rsp_o.comparison   = cmp_result;
  assign rsp_o.is_equal     = is_equal;

endmodule

// File: logic/alu_wb_regs.sv
// wishbone classic slave holding the ALU operand and operator registers and the readback mux
`timescale 1ns/1ps
`include "alu_config.svh"

module alu_wb_regs
  import alu_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  input  wb_m2s_t  wb_i,
  output wb_s2m_t  wb_o,
  output alu_req_t req_o,
  input  alu_rsp_t rsp_i
);

  localparam int unsigned XLEN = `ALU_XLEN;
  localparam int unsigned AW   = `ALU_WB_AW;

  // ------------------------------
  // state
  // ------------------------------
  logic [XLEN-1:0] opa_q;
  logic [XLEN-1:0] opb_q;
  alu_op           op_q;
  logic            ack_q;
  logic [XLEN-1:0] rdata_q;

  logic            req_valid;
  logic            wr_en;
  logic [AW-1:0]   reg_addr;
  logic [XLEN-1:0] rdata_d;

  // new request only while ack is low, so each transfer takes two cycles
  assign req_valid = wb_i.cyc && wb_i.stb && !ack_q;
  assign wr_en     = req_valid && wb_i.we;

  // word aligned offset, byte lane bits ignored
  assign reg_addr = {wb_i.adr[AW-1:3], 3'b000};

  // ------------------------------
  // ack and register writes
  // ------------------------------
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      ack_q <= 1'b0;
      opa_q <= '0;
      opb_q <= '0;
      op_q  <= ADD;
    end
    else
    begin
      ack_q <= req_valid;
      if (wr_en)
      begin
        // read-only and unmapped offsets fall through
        case (reg_addr)
          `ALU_REG_OPA: opa_q <= wb_i.dat;
          `ALU_REG_OPB: opb_q <= wb_i.dat;
          `ALU_REG_OP:  op_q  <= alu_op'(wb_i.dat[4:0]);
          default: ;
        endcase
      end
    end
  end

  // ------------------------------
  // readback
  // ------------------------------
  always_comb
  begin
    case (reg_addr)
      `ALU_REG_OPA:    rdata_d = opa_q;
      `ALU_REG_OPB:    rdata_d = opb_q;
      `ALU_REG_OP:     rdata_d = {{(XLEN-5){1'b0}}, op_q};
      `ALU_REG_RESULT: rdata_d = rsp_i.result;
      `ALU_REG_ADDER:  rdata_d = rsp_i.adder_result;
      // bit 0 comparison, bit 1 equal
      `ALU_REG_FLAGS:  rdata_d = {{(XLEN-2){1'b0}}, rsp_i.is_equal, rsp_i.comparison};
      default:         rdata_d = '0;
    endcase
  end

  // captured on the edge that raises ack
  always_ff @(posedge clk_i)
  begin
    if (req_valid && !wb_i.we)
      rdata_q <= rdata_d;
  end

  assign wb_o.ack = ack_q;
  assign wb_o.dat = rdata_q;

  // ALU sees the stored registers all the time
  assign req_o.operator  = op_q;
  assign req_o.operand_a = opa_q;
  assign req_o.operand_b = opb_q;

endmodule

// File: logic/alu_wb_top.sv
// top level of the ALU accelerator, joining the wishbone register slave to the ALU
`timescale 1ns/1ps

module alu_wb_top
  import alu_pkg::*;
(
  input  logic    clk_i,
  input  logic    reset_i,
  input  wb_m2s_t wb_i,
  output wb_s2m_t wb_o
);

  // ------------------------------
  // slave to ALU path
  // ------------------------------
  alu_req_t alu_req;
  alu_rsp_t alu_rsp;

  alu_wb_regs i_regs (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .wb_i    (wb_i),
    .wb_o    (wb_o),
    .req_o   (alu_req),
    .rsp_i   (alu_rsp)
  );

  // purely combinational, no added latency
  alu i_alu (
    .req_i (alu_req),
    .rsp_o (alu_rsp)
  );

endmodule

// File: bench/alu_ref_model.svh
// reference ALU model, LFSR and operator helpers, included inside the testbench module
`ifndef ALU_REF_MODEL_SVH
`define ALU_REF_MODEL_SVH

// ------------------------------
// random numbers
// ------------------------------

// right shifting galois form that folds the taps in on a one
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
  if (state[0])
    return (state >> 1) ^ 32'hA300_0000;
  else
    return state >> 1;
endfunction

// ------------------------------
// operator helpers
// ------------------------------

// index wraps over the 27 codes
function automatic alu_op op_from_index(input int unsigned idx);
  return alu_op'(idx % 27);
endfunction

// data word for the operator register
function automatic logic [`ALU_XLEN-1:0] op_word(input alu_op op);
  return {{(`ALU_XLEN-5){1'b0}}, op};
endfunction

// largest useful shift amount
function automatic logic [`ALU_XLEN-1:0] max_shamt(input alu_op op);
  return (op == SLLW || op == SRLW || op == SRAW) ? `ALU_XLEN'(31) : `ALU_XLEN'(63);
endfunction

// ------------------------------
// expected ALU response
// ------------------------------
function automatic alu_rsp_t ref_alu(input alu_op op, input logic [`ALU_XLEN-1:0] a,
                                     input logic [`ALU_XLEN-1:0] b);
  alu_rsp_t    rsp;
  logic        cmp;
  logic [31:0] w;
  rsp = '0;
  // subtract and all compares take a - b
  if (op == SUB || op == SUBW || op >= EQ)
    rsp.adder_result = a - b;
  else
    rsp.adder_result = a + b;
  rsp.is_equal = (rsp.adder_result == '0);
  case (op)
    EQ:          cmp = (a == b);
    NE:          cmp = (a != b);
    GTU:         cmp = (a > b);
    GEU:         cmp = (a >= b);
    LTU, SLTU:   cmp = (a < b);
    LEU, SLETU:  cmp = (a <= b);
    GTS:         cmp = ($signed(a) > $signed(b));
    GES:         cmp = ($signed(a) >= $signed(b));
    LTS, SLTS:   cmp = ($signed(a) < $signed(b));
    LES, SLETS:  cmp = ($signed(a) <= $signed(b));
    default:     cmp = 1'b0;
  endcase
  rsp.comparison = cmp;
  // word shifts on the low half only
  case (op)
    SLLW:    w = a[31:0] << b[4:0];
    SRLW:    w = a[31:0] >> b[4:0];
    default: w = $signed(a[31:0]) >>> b[4:0];
  endcase
  case (op)
    ADD, SUB:         rsp.result = rsp.adder_result;
    ADDW, SUBW:       rsp.result = {{(`ALU_XLEN-32){rsp.adder_result[31]}},
                                    rsp.adder_result[31:0]};
    ANDL:             rsp.result = a & b;
    ORL:              rsp.result = a | b;
    XORL:             rsp.result = a ^ b;
    SLL:              rsp.result = a << b[5:0];
    SRL:              rsp.result = a >> b[5:0];
    SRA:              rsp.result = $signed(a) >>> b[5:0];
    SLLW, SRLW, SRAW: rsp.result = {{(`ALU_XLEN-32){w[31]}}, w};
    default:          rsp.result = {{(`ALU_XLEN-1){1'b0}}, cmp};
  endcase
  return rsp;
endfunction

`endif

// File: bench/alu_tb.sv
// testbench of the ALU accelerator, drives the wishbone slave and checks against a reference model
`timescale 1ns/1ps
`include "alu_config.svh"

module alu_tb
  import alu_pkg::*;
();

  localparam int unsigned     XLEN        = `ALU_XLEN;
  localparam int unsigned     ACK_TIMEOUT = 20;
  localparam logic [XLEN-1:0] MIN_S       = {1'b1, {(XLEN-1){1'b0}}};
  localparam logic [XLEN-1:0] MAX_S       = {1'b0, {(XLEN-1){1'b1}}};

  logic        clk_i;
  logic        reset_i;
  wb_m2s_t     wb_i;
  wb_s2m_t     wb_o;
  int unsigned checks;
  int unsigned errors;
  int unsigned tests;
  logic [31:0] lfsr_q;

  `include "alu_ref_model.svh"

  alu_wb_top i_dut (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .wb_i    (wb_i),
    .wb_o    (wb_o)
  );

  always #2 clk_i = ~clk_i;

  // one LFSR step per bit taken
  function automatic logic [XLEN-1:0] rand_bits(input int unsigned n);
    logic [XLEN-1:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++)
    begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[XLEN-2:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic alu_op rand_op(input int unsigned base, input int unsigned count);
    logic [XLEN-1:0] raw;
    int unsigned     pick;
    raw  = rand_bits(8);
    pick = raw[7:0] % count;
    return op_from_index(base + pick);
  endfunction

  // ------------------------------
  // bus tasks
  // ------------------------------
  task automatic wait_ack(input string what);
    int unsigned n;
    n = 0;
    while (!wb_o.ack && n < ACK_TIMEOUT)
    begin
      @(negedge clk_i);
      n++;
    end
    if (!wb_o.ack)
    begin
      errors++;
      $display("timeout: no ack within %0d cycles on %s", ACK_TIMEOUT, what);
    end
  endtask

  // ack has to be gone one cycle after the strobe drops
  task automatic end_transfer(input string what);
    wb_i.cyc = 1'b0;
    wb_i.stb = 1'b0;
    wb_i.we  = 1'b0;
    @(negedge clk_i);
    if (wb_o.ack)
    begin
      errors++;
      $display("ack stayed high for more than one cycle on %s", what);
    end
  endtask

  task automatic wb_write(input logic [`ALU_WB_AW-1:0] addr, input logic [XLEN-1:0] data);
    @(negedge clk_i);
    wb_i.cyc = 1'b1;
    wb_i.stb = 1'b1;
    wb_i.we  = 1'b1;
    wb_i.adr = addr;
    wb_i.dat = data;
    wait_ack($sformatf("write to offset %h", addr));
    end_transfer($sformatf("write to offset %h", addr));
  endtask

  task automatic wb_read(input logic [`ALU_WB_AW-1:0] addr, output logic [XLEN-1:0] data);
    @(negedge clk_i);
    wb_i.cyc = 1'b1;
    wb_i.stb = 1'b1;
    wb_i.we  = 1'b0;
    wb_i.adr = addr;
    wait_ack($sformatf("read of offset %h", addr));
    data = wb_o.dat;
    end_transfer($sformatf("read of offset %h", addr));
  endtask

  // ------------------------------
  // compare tasks
  // ------------------------------
  task automatic check_word(input string what, input logic [XLEN-1:0] got,
                            input logic [XLEN-1:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("CHECK FAILED at %0t: %s read %h, expected %h", $time, what, got, exp);
    end
  endtask

  // bit 0 comparison, bit 1 equal, rest zero
  task automatic check_flags(input string what, input logic [XLEN-1:0] word, input alu_rsp_t exp);
    alu_rsp_t got;
    got            = '0;
    got.comparison = word[0];
    got.is_equal   = word[1];
    checks++;
    if (got.comparison !== exp.comparison || got.is_equal !== exp.is_equal
        || word[XLEN-1:2] !== '0)
    begin
      errors++;
      $display("CHECK FAILED at %0t: %s read %h, expected cmp %b eq %b", $time, what, word,
               exp.comparison, exp.is_equal);
    end
  endtask

  task automatic run_case(input alu_op op, input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
    alu_rsp_t        exp;
    logic [XLEN-1:0] rd;
    string           tag;
    exp = ref_alu(op, a, b);
    tag = $sformatf("%s a=%h b=%h", op.name(), a, b);
    wb_write(`ALU_REG_OPA, a);
    wb_write(`ALU_REG_OPB, b);
    wb_write(`ALU_REG_OP, op_word(op));
    wb_read(`ALU_REG_RESULT, rd);
    check_word({tag, " result"}, rd, exp.result);
    wb_read(`ALU_REG_ADDER, rd);
    check_word({tag, " adder"}, rd, exp.adder_result);
    wb_read(`ALU_REG_FLAGS, rd);
    check_flags({tag, " flags"}, rd, exp);
  endtask

  task automatic report_test(input string name, input int unsigned chk0, input int unsigned err0);
    tests++;
    $display("test %-10s %0d checks, %0d errors", name, checks - chk0, errors - err0);
  endtask

  // ------------------------------
  // test sequence
  // ------------------------------
  initial
  begin
    int unsigned     chk0;
    int unsigned     err0;
    logic [XLEN-1:0] rd;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    alu_op           op;
    clk_i   = 1'b0;
    reset_i = 1'b1;
    wb_i    = '0;
    checks  = 0;
    errors  = 0;
    tests   = 0;
    lfsr_q  = 32'h6ebc;
    repeat (5) @(negedge clk_i);
    reset_i = 1'b0;

    chk0 = checks;
    err0 = errors;
    wb_read(`ALU_REG_OPA, rd);
    check_word("reset opa", rd, '0);
    wb_read(`ALU_REG_OPB, rd);
    check_word("reset opb", rd, '0);
    wb_read(`ALU_REG_OP, rd);
    check_word("reset operator", rd, op_word(ADD));
    wb_read(`ALU_REG_RESULT, rd);
    check_word("reset result", rd, '0);
    wb_read(`ALU_REG_ADDER, rd);
    check_word("reset adder", rd, '0);
    wb_read(`ALU_REG_FLAGS, rd);
    check_word("reset flags", rd, 64'h2);
    wb_read(8'h30, rd);
    check_word("unmapped offset", rd, '0);
    report_test("reset", chk0, err0);

    // ADD up to XORL sit at codes 0 to 6
    chk0 = checks;
    err0 = errors;
    for (int i = 0; i < 60; i++)
    begin
      op = rand_op(0, 7);
      a  = rand_bits(XLEN);
      b  = rand_bits(XLEN);
      run_case(op, a, b);
    end
    report_test("logic_add", chk0, err0);

    // edge amounts first on operands with the top bits set
    chk0 = checks;
    err0 = errors;
    for (int k = 0; k < 6; k++)
    begin
      op = op_from_index(int'(SLL) + k);
      a  = rand_bits(XLEN) | MIN_S | 64'h8000_0000;
      run_case(op, a, '0);
      run_case(op, a, max_shamt(op));
    end
    for (int i = 0; i < 48; i++)
    begin
      op = rand_op(int'(SLL), 6);
      a  = rand_bits(XLEN);
      b  = rand_bits(XLEN);
      run_case(op, a, b);
    end
    report_test("shifts", chk0, err0);

    chk0 = checks;
    err0 = errors;
    for (int i = 0; i < 80; i++)
    begin
      op = rand_op(int'(EQ), 14);
      a  = rand_bits(XLEN);
      b  = rand_bits(XLEN);
      run_case(op, a, b);
    end
    // equal operands, then the extremes where signed and unsigned order disagree
    for (int k = 0; k < 14; k++)
    begin
      op = op_from_index(int'(EQ) + k);
      a  = rand_bits(XLEN);
      run_case(op, a, a);
      run_case(op, MIN_S, MAX_S);
      run_case(op, MAX_S, MIN_S);
    end
    report_test("compares", chk0, err0);

    chk0 = checks;
    err0 = errors;
    wb_write(`ALU_REG_OPA, 64'h0123_4567_89ab_cdef);
    wb_write(`ALU_REG_OPB, 64'hfedc_ba98_7654_3210);
    wb_write(`ALU_REG_OP, op_word(XORL));
    wb_write(`ALU_REG_RESULT, '1);
    wb_write(`ALU_REG_FLAGS, '1);
    wb_write(`ALU_REG_ADDER, '1);
    wb_write(8'h38, '1);
    wb_read(`ALU_REG_OPA, rd);
    check_word("opa after read-only writes", rd, 64'h0123_4567_89ab_cdef);
    wb_read(`ALU_REG_OPB, rd);
    check_word("opb after read-only writes", rd, 64'hfedc_ba98_7654_3210);
    wb_read(`ALU_REG_OP, rd);
    check_word("operator after read-only writes", rd, op_word(XORL));
    wb_read(`ALU_REG_RESULT, rd);
    check_word("xor result after read-only writes", rd, 64'hffff_ffff_ffff_ffff);
    report_test("bus", chk0, err0);

    $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

// File: Bender.yml
package:
  name: alu_wb_accel

sources:
  - include_dirs:
      - logic
    files:
      - logic/alu_pkg.sv
      - logic/alu.sv
      - logic/alu_wb_regs.sv
      - logic/alu_wb_top.sv
  - target: test
    include_dirs:
      - logic
      - bench
    files:
      - bench/alu_tb.sv

// File: verilog.f
+incdir+logic
+incdir+bench
logic/alu_pkg.sv
logic/alu.sv
logic/alu_wb_regs.sv
logic/alu_wb_top.sv
bench/alu_tb.sv
